/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_sram_testchip
RTL_TOP   ?= sram_testchip_top
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "TEST OK" $(LOG); then echo "Simulation ended without a result"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* sim/sram_testchip_checker.sv */
// Strobe and done timing checks
`timescale 1ns/1ps

module sram_testchip_checker (
   input logic wb_clk_i,
   input logic reset_i,
   input logic access_i,
   input logic done_i,
   input logic scan_out_i
);

   // Access to done is a fixed two cycle latency
   a_done_latency: assert property (@(posedge wb_clk_i) disable iff (reset_i)
      access_i |-> ##2 done_i)
      else $error("done_o missing two cycles after access_i");

   a_done_cause: assert property (@(posedge wb_clk_i) disable iff (reset_i)
      $rose(done_i) |-> $past(access_i, 2))
      else $error("done_o rose without access_i two cycles earlier");

   a_done_pulse: assert property (@(posedge wb_clk_i) disable iff (reset_i)
      done_i |=> !done_i)
      else $error("done_o held longer than one cycle");

   // Outputs settle low once reset has been seen for a cycle
   a_reset_quiet: assert property (@(posedge wb_clk_i)
      reset_i && $past(reset_i) |-> !done_i && !scan_out_i)
      else $error("done_o or scan_out_o high during reset");

endmodule

bind sram_testchip_top sram_testchip_checker u_checker (
   .wb_clk_i   (wb_clk_i),
   .reset_i    (reset_i),
   .access_i   (access_i),
   .done_i     (done_o),
   .scan_out_i (scan_out_o)
);

/* sim/tb_sram_testchip.sv */
// SRAM test chip testbench
`timescale 1ns/1ps
`include "sram_test_defs.svh"

module tb_sram_testchip import sram_test_pkg::*;;

   localparam int DONE_TIMEOUT = 8;
   localparam int BYTE_W       = `SRAM_DATA_W / `SRAM_WMASK_W;
   localparam int A0_W         = $clog2(`SRAM0_DEPTH);

   // One row of the stimulus table
   typedef struct packed {
      sram_cmd_t    cmd;
      sram_result_t expected;
   } test_entry_t;

   logic wb_clk_i = 1'b0;
   logic reset_i;
   logic scan_in_i;
   logic scan_en_i;
   logic load_i;
   logic access_i;
   logic scan_out_o;
   logic done_o;

   // Reference copies of both memories
   sram_data_t  ref0 [`SRAM0_DEPTH];
   sram_data_t  ref1 [`SRAM1_DEPTH];
   test_entry_t entries [$];
   integer      seed     = 32'hc520_50e2;
   int          errors   = 0;
   int          timeouts = 0;

   sram_testchip_top UUT (
      .wb_clk_i   (wb_clk_i),
      .reset_i    (reset_i),
      .scan_in_i  (scan_in_i),
      .scan_en_i  (scan_en_i),
      .load_i     (load_i),
      .access_i   (access_i),
      .scan_out_o (scan_out_o),
      .done_o     (done_o)
   );

   always #2 wb_clk_i = ~wb_clk_i;

   function automatic sram_data_t merge_bytes(input sram_data_t old_w, input sram_data_t new_w,
                                              input sram_wmask_t mask);
      sram_data_t w;
      w = old_w;
      for (int b = 0; b < `SRAM_WMASK_W; b++) begin
         if (mask[b]) w[b*BYTE_W +: BYTE_W] = new_w[b*BYTE_W +: BYTE_W];
      end
      return w;
   endfunction

   // Port 1 reads land before the port 0 write, so they see the old word
   function automatic sram_result_t apply_reference(input sram_cmd_t c);
      sram_result_t r;
      r = '0;
      if (!c.csb1[0]) r.dout1 = r.dout1 | ref0[c.addr1[A0_W-1:0]];
      if (!c.csb1[1]) r.dout1 = r.dout1 | ref1[c.addr1];
      if (!c.csb0[0] && c.web0) r.dout0 = r.dout0 | ref0[c.addr0[A0_W-1:0]];
      if (!c.csb0[1] && c.web0) r.dout0 = r.dout0 | ref1[c.addr0];
      if (!c.csb0[0] && !c.web0) begin
         ref0[c.addr0[A0_W-1:0]] = merge_bytes(ref0[c.addr0[A0_W-1:0]], c.din0, c.wmask0);
      end
      if (!c.csb0[1] && !c.web0) ref1[c.addr0] = merge_bytes(ref1[c.addr0], c.din0, c.wmask0);
      return r;
   endfunction

   task automatic add_entry(input chip_sel_t csb0, input chip_sel_t csb1, input logic web0,
                            input sram_wmask_t wmask0, input sram_addr_t addr0,
                            input sram_data_t din0, input sram_addr_t addr1);
      test_entry_t e;
      e.cmd      = '{csb0, csb1, web0, wmask0, addr0, din0, addr1};
      e.expected = apply_reference(e.cmd);
      entries.push_back(e);
   endtask

   task automatic build_table();
      sram_data_t w [8];
      foreach (w[i]) w[i] = $random(seed);
      // Nothing selected
      add_entry(2'b11, 2'b11, 1'b1, 4'h0, 10'h000, 32'h0, 10'h000);
      // Full mask write and readback on each chip
      add_entry(2'b10, 2'b11, 1'b0, 4'hf, 10'h010, w[0], 10'h000);
      add_entry(2'b10, 2'b10, 1'b1, 4'h0, 10'h010, 32'h0, 10'h010);
      add_entry(2'b01, 2'b11, 1'b0, 4'hf, 10'h020, w[1], 10'h000);
      add_entry(2'b01, 2'b01, 1'b1, 4'h0, 10'h020, 32'h0, 10'h020);
      // Deselected chips hide the stored words
      add_entry(2'b11, 2'b11, 1'b1, 4'h0, 10'h010, 32'h0, 10'h020);
      // Partial mask keeps bytes 1 and 3
      add_entry(2'b10, 2'b11, 1'b0, 4'h5, 10'h010, w[2], 10'h000);
      add_entry(2'b10, 2'b10, 1'b1, 4'h0, 10'h010, 32'h0, 10'h010);
      // Chip isolation, then both chips ORed
      add_entry(2'b01, 2'b11, 1'b0, 4'hf, 10'h010, w[3], 10'h000);
      add_entry(2'b10, 2'b01, 1'b1, 4'h0, 10'h010, 32'h0, 10'h010);
      add_entry(2'b00, 2'b00, 1'b1, 4'h0, 10'h010, 32'h0, 10'h010);
      // Chip 0 wraps above 255, chip 1 does not
      add_entry(2'b10, 2'b11, 1'b0, 4'hf, 10'h130, w[4], 10'h000);
      add_entry(2'b01, 2'b11, 1'b0, 4'hf, 10'h130, w[5], 10'h000);
      add_entry(2'b01, 2'b11, 1'b0, 4'hf, 10'h030, w[6], 10'h000);
      add_entry(2'b10, 2'b01, 1'b1, 4'h0, 10'h030, 32'h0, 10'h130);
      add_entry(2'b01, 2'b10, 1'b1, 4'h0, 10'h030, 32'h0, 10'h230);
      // Port 1 read of the word being written
      add_entry(2'b01, 2'b01, 1'b0, 4'hf, 10'h020, w[7], 10'h020);
      add_entry(2'b10, 2'b10, 1'b0, 4'h8, 10'h010, ~w[0], 10'h010);
      add_entry(2'b01, 2'b10, 1'b1, 4'h0, 10'h020, 32'h0, 10'h010);
   endtask

   // Sends the MSB first while the result side stays quiet
   task automatic shift_command(input sram_cmd_t c);
      logic [`CMD_BITS-1:0] bits;
      bits = c;
      for (int i = `CMD_BITS-1; i >= 0; i--) begin
         assert (!done_o && !scan_out_o) else begin
            $display("[FAIL] done_o %h scan_out_o %h while shifting a command",
                     done_o, scan_out_o);
            errors++;
         end
         scan_in_i = bits[i];
         scan_en_i = 1'b1;
         @(posedge wb_clk_i);
         #1;
      end
      scan_en_i = 1'b0;
      scan_in_i = 1'b0;
   endtask

   task automatic pulse_strobes();
      load_i = 1'b1;
      @(posedge wb_clk_i);
      #1;
      load_i   = 1'b0;
      access_i = 1'b1;
      @(posedge wb_clk_i);
      #1;
      access_i = 1'b0;
   endtask

   task automatic wait_for_done(output logic seen);
      int n;
      seen = 1'b0;
      n    = 0;
      while (!seen && n < DONE_TIMEOUT) begin
         @(posedge wb_clk_i);
         #1;
         seen = done_o;
         n++;
      end
   endtask

   // Sample before each shift edge so the dout0 MSB comes out first
   task automatic shift_result(output sram_result_t r);
      logic [`RESULT_BITS-1:0] bits;
      for (int i = `RESULT_BITS-1; i >= 0; i--) begin
         bits[i]   = scan_out_o;
         scan_en_i = 1'b1;
         @(posedge wb_clk_i);
         #1;
      end
      scan_en_i = 1'b0;
      r = bits;
   endtask

   initial begin
      sram_result_t got;
      logic         seen;
      reset_i   = 1'b1;
      scan_in_i = 1'b0;
      scan_en_i = 1'b0;
      load_i    = 1'b0;
      access_i  = 1'b0;
      build_table();
      repeat (16) @(posedge wb_clk_i);
      #1;
      reset_i = 1'b0;

      foreach (entries[k]) begin
         shift_command(entries[k].cmd);
         pulse_strobes();
         wait_for_done(seen);
         if (!seen) begin
            $display("Timeout: done_o never rose after the access of entry %0d", k);
            timeouts++;
         end else begin
            shift_result(got);
            assert (got.dout0 === entries[k].expected.dout0) else begin
               $display("[FAIL] entry %0d dout0 got %h expected %h",
                        k, got.dout0, entries[k].expected.dout0);
               errors++;
            end
            assert (got.dout1 === entries[k].expected.dout1) else begin
               $display("[FAIL] entry %0d dout1 got %h expected %h",
                        k, got.dout1, entries[k].expected.dout1);
               errors++;
            end
         end
      end

      $display("Summary: %0d entries, %0d value errors, %0d timeouts",
               entries.size(), errors, timeouts);
      if (errors == 0 && timeouts == 0) begin
         $display("TEST OK");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

/* tb.f */
+incdir+verilog
verilog/sram_test_pkg.sv
verilog/scan_chain.sv
verilog/sram_1rw1r.sv
verilog/sram_bank.sv
verilog/result_capture.sv
verilog/sram_testchip_top.sv
sim/sram_testchip_checker.sv
sim/tb_sram_testchip.sv

/* verilog/result_capture.sv */
// Result capture and serial output
`timescale 1ns/1ps
`include "sram_test_defs.svh"

module result_capture import sram_test_pkg::*; (
   input  logic         wb_clk_i,
   input  logic         reset_i,
   input  sram_result_t rdata_i,
   input  logic         rd_done_i,
   input  logic         scan_en_i,
   output logic         scan_out_o,
   output logic         done_o
);

   // Result register, MSB drives the serial output
   logic [`RESULT_BITS-1:0] result_q;
   logic                    done_q;

   // A load wins over a shift in the same cycle
   always_ff @(posedge wb_clk_i) begin
      if (reset_i) begin
         result_q <= '0;
      end else if (rd_done_i) begin
         result_q <= rdata_i;
      end else if (scan_en_i) begin
         // Move toward the MSB, zeros fill from the bottom
         result_q <= {result_q[`RESULT_BITS-2:0], 1'b0};
      end
   end

   // One cycle pulse once the register holds fresh data
   always_ff @(posedge wb_clk_i) begin
      if (reset_i) begin
         done_q <= 1'b0;
      end else begin
         done_q <= rd_done_i;
      end
   end

   assign scan_out_o = result_q[`RESULT_BITS-1];
   assign done_o     = done_q;

endmodule

/* verilog/scan_chain.sv */
// Command scan chain
`timescale 1ns/1ps
`include "sram_test_defs.svh"

module scan_chain import sram_test_pkg::*; (
   input  logic      wb_clk_i,
   input  logic      reset_i,
   input  logic      scan_in_i,
   input  logic      scan_en_i,
   input  logic      load_i,
   output sram_cmd_t cmd_o
);

   // Serial shift register, filled MSB first
   logic [`CMD_BITS-1:0] shift_q;

   // Command seen by the memories
   sram_cmd_t cmd_q;

   // New bits enter at the LSB so the first bit sent ends up at the MSB
   always_ff @(posedge wb_clk_i) begin
      if (scan_en_i) begin
         shift_q <= {shift_q[`CMD_BITS-2:0], scan_in_i};
      end
   end

   // Load copies the chain contents present before this edge
   always_ff @(posedge wb_clk_i) begin
      if (reset_i) begin
         // All ones keeps every chip deselected
         cmd_q <= '1;
      end else if (load_i) begin
         cmd_q <= sram_cmd_t'(shift_q);
      end
   end

   assign cmd_o = cmd_q;

endmodule

/* verilog/sram_1rw1r.sv */
// Dual port SRAM model
`timescale 1ns/1ps

module sram_1rw1r import sram_test_pkg::*; #(
   parameter int DEPTH = 256
) (
   input  logic        wb_clk_i,
   // Port 0, read or write
   input  logic        en0_i,
   input  logic        web0_i,
   input  sram_wmask_t wmask0_i,
   input  sram_addr_t  addr0_i,
   input  sram_data_t  din0_i,
   output sram_data_t  dout0_o,
   // Port 1, read only
   input  logic        en1_i,
   input  sram_addr_t  addr1_i,
   output sram_data_t  dout1_o
);

   localparam int AW     = $clog2(DEPTH);
   localparam int BYTE_W = $bits(sram_data_t) / $bits(sram_wmask_t);

   sram_data_t mem [DEPTH];

   logic [AW-1:0] word0;
   logic [AW-1:0] word1;
   sram_data_t    dout0_q;
   sram_data_t    dout1_q;

   // Upper address bits beyond the depth are ignored, so addresses wrap
   assign word0 = addr0_i[AW-1:0];
   assign word1 = addr1_i[AW-1:0];

   // Byte masked write on port 0
   always_ff @(posedge wb_clk_i) begin
      if (en0_i && !web0_i) begin
         for (int i = 0; i < $bits(sram_wmask_t); i++) begin
            if (wmask0_i[i]) begin
               mem[word0][i*BYTE_W +: BYTE_W] <= din0_i[i*BYTE_W +: BYTE_W];
            end
         end
      end
   end

   // Registered reads, zero when idle or writing
   // Port 1 sees the old word on a same-address write
   always_ff @(posedge wb_clk_i) begin
      if (en0_i && web0_i) begin
         dout0_q <= mem[word0];
      end else begin
         dout0_q <= '0;
      end
      if (en1_i) begin
         dout1_q <= mem[word1];
      end else begin
         dout1_q <= '0;
      end
   end

   assign dout0_o = dout0_q;
   assign dout1_o = dout1_q;

endmodule

/* verilog/sram_bank.sv */
// SRAM bank with chip select decode
`timescale 1ns/1ps
`include "sram_test_defs.svh"

module sram_bank import sram_test_pkg::*; (
   input  logic         wb_clk_i,
   input  logic         reset_i,
   input  sram_cmd_t    cmd_i,
   input  logic         access_i,
   output sram_result_t rdata_o,
   output logic         rd_done_o
);

   logic       access_ok;
   chip_sel_t  en0;
   chip_sel_t  en1;
   sram_data_t dout0 [`SRAM_CHIPS];
   sram_data_t dout1 [`SRAM_CHIPS];
   logic       rd_done_q;

   // Access strobe acts as the clock enable of every selected port
   assign access_ok = access_i & ~reset_i;
   assign en0 = {`SRAM_CHIPS{access_ok}} & ~cmd_i.csb0;
   assign en1 = {`SRAM_CHIPS{access_ok}} & ~cmd_i.csb1;

   sram_1rw1r #(.DEPTH(`SRAM0_DEPTH)) u_sram0 (
      .wb_clk_i (wb_clk_i),
      .en0_i    (en0[0]),
      .web0_i   (cmd_i.web0),
      .wmask0_i (cmd_i.wmask0),
      .addr0_i  (cmd_i.addr0),
      .din0_i   (cmd_i.din0),
      .dout0_o  (dout0[0]),
      .en1_i    (en1[0]),
      .addr1_i  (cmd_i.addr1),
      .dout1_o  (dout1[0])
   );

   sram_1rw1r #(.DEPTH(`SRAM1_DEPTH)) u_sram1 (
      .wb_clk_i (wb_clk_i),
      .en0_i    (en0[1]),
      .web0_i   (cmd_i.web0),
      .wmask0_i (cmd_i.wmask0),
      .addr0_i  (cmd_i.addr0),
      .din0_i   (cmd_i.din0),
      .dout0_o  (dout0[1]),
      .en1_i    (en1[1]),
      .addr1_i  (cmd_i.addr1),
      .dout1_o  (dout1[1])
   );

   // Idle ports drive zero, so an OR merges the chips
   always_comb begin
      rdata_o = '0;
      for (int c = 0; c < `SRAM_CHIPS; c++) begin
         rdata_o.dout0 = rdata_o.dout0 | dout0[c];
         rdata_o.dout1 = rdata_o.dout1 | dout1[c];
      end
   end

   // Read data is valid in the cycle after the access edge
   always_ff @(posedge wb_clk_i) begin
      if (reset_i) begin
         rd_done_q <= 1'b0;
      end else begin
         rd_done_q <= access_i;
      end
   end

   assign rd_done_o = rd_done_q;

endmodule

/* verilog/sram_test_defs.svh */
// SRAM test harness widths
`ifndef SRAM_TEST_DEFS_SVH
`define SRAM_TEST_DEFS_SVH

// Word and mask geometry shared by every macro
`define SRAM_ADDR_W   10
`define SRAM_DATA_W   32
`define SRAM_WMASK_W  4

// Memories on the harness
`define SRAM_CHIPS    2
`define SRAM0_DEPTH   256
`define SRAM1_DEPTH   1024

// Serial chain lengths
// Command chain covers csb0, csb1, web0, wmask0, addr0, din0 and addr1
`define CMD_BITS      61
`define RESULT_BITS   64

`endif

/* verilog/sram_test_pkg.sv */
// SRAM test harness types
`include "sram_test_defs.svh"

package sram_test_pkg;

   typedef logic [`SRAM_ADDR_W-1:0]  sram_addr_t;
   typedef logic [`SRAM_DATA_W-1:0]  sram_data_t;
   // Bit i enables byte i
   typedef logic [`SRAM_WMASK_W-1:0] sram_wmask_t;
   // Active low, one bit per chip
   typedef logic [`SRAM_CHIPS-1:0]   chip_sel_t;

   // Command word as it sits in the scan chain, MSB shifted in first
   typedef struct packed {
      chip_sel_t   csb0;
      chip_sel_t   csb1;
      logic        web0;     // low selects a write
      sram_wmask_t wmask0;
      sram_addr_t  addr0;
      sram_data_t  din0;
      sram_addr_t  addr1;
   } sram_cmd_t;

   // Captured read data, dout0 leaves the chain first
   typedef struct packed {
      sram_data_t dout0;
      sram_data_t dout1;
   } sram_result_t;

endpackage

/* verilog/sram_testchip_top.sv */
// SRAM test chip top level
`timescale 1ns/1ps

module sram_testchip_top import sram_test_pkg::*; (
   input  logic wb_clk_i,
   input  logic reset_i,
   input  logic scan_in_i,
   input  logic scan_en_i,
   input  logic load_i,
   input  logic access_i,
   output logic scan_out_o,
   output logic done_o
);

   sram_cmd_t    cmd;
   sram_result_t rdata;
   logic         rd_done;

   // Serial command in
   scan_chain u_scan_chain (
      .wb_clk_i  (wb_clk_i),
      .reset_i   (reset_i),
      .scan_in_i (scan_in_i),
      .scan_en_i (scan_en_i),
      .load_i    (load_i),
      .cmd_o     (cmd)
   );

   // Memories under test
   sram_bank u_sram_bank (
      .wb_clk_i  (wb_clk_i),
      .reset_i   (reset_i),
      .cmd_i     (cmd),
      .access_i  (access_i),
      .rdata_o   (rdata),
      .rd_done_o (rd_done)
   );

   // Serial result out
   result_capture u_result_capture (
      .wb_clk_i   (wb_clk_i),
      .reset_i    (reset_i),
      .rdata_i    (rdata),
      .rd_done_i  (rd_done),
      .scan_en_i  (scan_en_i),
      .scan_out_o (scan_out_o),
      .done_o     (done_o)
   );

endmodule
